// ==== Makefile ====
# Verilator build and run of the USB full-speed transmit testbench.
# Any variable below can be overridden on the command line.
VERILATOR ?= verilator
TOP       ?= tb_usb_tx
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/usb_line_driver.sv ====
`timescale 1ns/10ps

module usb_line_driver (
  input  logic i_clk_48MHz,
  input  logic i_rst_n,
  input  logic i_bit_stb,
  input  logic i_tx_bit,
  input  logic i_tx_eop,
  input  logic i_tx_active,
  output logic o_dp,
  output logic o_dn,
  output logic o_oe
);
  import usb_spec_pkg::*;

  line_state_e line_q;
  logic [1:0]  se0_cnt;
  logic        oe_q;

  // Everything moves on the bit strobe only.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      line_q <= LINE_J;
      se0_cnt <= '0;
      oe_q <= 1'b0;
    end else if (i_bit_stb) begin
      // Enable lines up with the first cell driven.
      oe_q <= i_tx_active;
      if (!i_tx_active) begin
        // Idle bus sits at J.
        line_q <= LINE_J;
        se0_cnt <= '0;
      end else if (i_tx_eop) begin
        if (se0_cnt < 2'd2) begin
          line_q <= LINE_SE0;
          se0_cnt <= se0_cnt + 2'd1;
        end else begin
          // Back to J to close the EOP.
          line_q <= LINE_J;
          se0_cnt <= '0;
        end
      end else if (!i_tx_bit) begin
        // NRZI, a zero flips the line.
        line_q <= (line_q == LINE_J) ? LINE_K : LINE_J;
      end
    end
  end

  assign {o_dp, o_dn} = line_q;
  assign o_oe = oe_q;

endmodule

// ==== hw/usb_pkt_serializer.sv ====
`timescale 1ns/10ps

module usb_pkt_serializer #(
  parameter int MAX_PKT = 8
) (
  input  logic                           i_clk_48MHz,
  input  logic                           i_rst_n,
  input  logic                           i_start,
  input  usb_spec_pkg::usb_pid_e         i_pid,
  input  logic [$clog2(MAX_PKT+1)-1:0]   i_len,
  input  logic [7:0]                     i_rd_byte,
  output logic [$clog2(MAX_PKT)-1:0]     o_rd_idx,
  output logic                           o_busy,
  output logic                           o_bit_stb,
  output logic                           o_tx_bit,
  output logic                           o_tx_eop,
  output logic                           o_tx_active
);
  import usb_spec_pkg::*;
  import usb_tx_pkg::*;

  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int LEN_W = $clog2(MAX_PKT + 1);
  // x^16+x^15+x^2+1 in reflected form.
  localparam logic [15:0] CRC16_POLY = 16'ha001;

  ser_state_e           state;
  logic [1:0]           div_cnt;
  logic [7:0]           shreg;
  logic [2:0]           bit_cnt;
  logic [LEN_W-1:0]     data_cnt;
  logic [15:0]          crc;
  logic [15:0]          crc_next;
  logic [STUFF_RUN-1:0] hist;
  logic                 stuff;
  logic                 crc_loop;
  logic                 is_data;
  logic                 in_pkt;

  // Divide by four for the 12 MHz bit cell.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 2'd1;
    end
  end

  assign o_bit_stb = (div_cnt == 2'd3);

  assign in_pkt = (state != SER_IDLE);
  assign is_data = (i_pid[1:0] == PIDGRP_DATA);

  // Six ones just went out, so this cell is a stuffed zero.
  assign stuff = &hist;

  // Nothing is sent in EOP cells apart from a possible stuffed zero.
  assign o_tx_bit = shreg[0] && !stuff && (state != SER_EOP);
  assign o_tx_eop = (state == SER_EOP) && !stuff;
  assign o_tx_active = in_pkt;
  assign o_busy = in_pkt;

  // Payload index, read ahead one byte.
  assign o_rd_idx = data_cnt[IDX_W-1:0];

  // One CRC step on the bit now leaving.
  assign crc_loop = shreg[0] ^ crc[0];
  assign crc_next = (crc >> 1) ^ ({16{crc_loop}} & CRC16_POLY);

  // Field sequencing, advancing on non-stuffed cells only.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= SER_IDLE;
      bit_cnt <= '0;
      data_cnt <= '0;
      hist <= '0;
    end else if (state == SER_IDLE) begin
      if (i_start) begin
        state <= SER_SYNC;
        bit_cnt <= '0;
        data_cnt <= '0;
        hist <= '0;
      end
    end else if (o_bit_stb) begin
      hist <= {hist[STUFF_RUN-2:0], o_tx_bit};
      if (!stuff) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (state == SER_EOP) begin
          // Two SE0 cells, then one J cell.
          if (bit_cnt == 3'd2) begin
            state <= SER_IDLE;
          end
        end else if (bit_cnt == 3'd7) begin
          case (state)
            SER_SYNC: state <= SER_PID;
            SER_PID: begin
              if (!is_data) begin
                state <= SER_EOP;
              end else if (i_len == '0) begin
                state <= SER_CRC_LO;
              end else begin
                state <= SER_DATA;
                data_cnt <= data_cnt + 1'b1;
              end
            end
            SER_DATA: begin
              if (data_cnt == i_len) begin
                state <= SER_CRC_LO;
              end else begin
                data_cnt <= data_cnt + 1'b1;
              end
            end
            SER_CRC_LO: state <= SER_CRC_HI;
            SER_CRC_HI: state <= SER_EOP;
            default:    state <= SER_IDLE;
          endcase
        end
      end
    end
  end

  // Shift register and CRC. Both hold during a stuffed cell.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_start && (state == SER_IDLE)) begin
      shreg <= SYNC_BYTE;
      crc <= CRC16_SEED;
    end else if (o_bit_stb && !stuff && in_pkt && (state != SER_EOP)) begin
      if (state == SER_DATA) begin
        crc <= crc_next;
      end
      if (bit_cnt != 3'd7) begin
        shreg <= shreg >> 1;
      end else begin
        case (state)
          // PID nibble then its complement.
          SER_SYNC:   shreg <= {~i_pid, i_pid};
          // Empty payload goes straight to the CRC of nothing.
          SER_PID:    shreg <= (i_len == '0) ? ~crc[7:0] : i_rd_byte;
          // The last payload bit is folded in via crc_next.
          SER_DATA:   shreg <= (data_cnt == i_len) ? ~crc_next[7:0] : i_rd_byte;
          SER_CRC_LO: shreg <= ~crc[15:8];
          default:    shreg <= shreg;
        endcase
      end
    end
  end

endmodule

// ==== hw/usb_spec_pkg.sv ====
package usb_spec_pkg;

  // PIDs a device sends, as the low nibble of the PID byte.
  // Bits [1:0] hold the coding group.
  typedef enum logic [3:0] {
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

  // Coding group shared by DATA0 and DATA1.
  localparam logic [1:0] PIDGRP_DATA = 2'b11;

  // Bus state as {dp, dn} for a full-speed device.
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_K   = 2'b01,
    LINE_J   = 2'b10
  } line_state_e;

  // Seven zeros then a one, sent LSB first.
  // On the wire this reads KJKJKJKK.
  localparam logic [7:0] SYNC_BYTE = 8'h80;

  // CRC16 register starts at all ones.
  localparam logic [15:0] CRC16_SEED = 16'hffff;

  // Good-packet remainder 0x800d, bit reversed to suit an LSB-first register.
  localparam logic [15:0] CRC16_RESIDUE = 16'hb001;

  // A zero is forced after this many ones in a row.
  localparam int STUFF_RUN = 6;

endpackage

// ==== hw/usb_tx_intake.sv ====
`timescale 1ns/10ps

module usb_tx_intake #(
  parameter int MAX_PKT = 8
) (
  input  logic                           i_clk_48MHz,
  input  logic                           i_rst_n,
  input  logic                           i_wr_en,
  input  logic [$clog2(MAX_PKT)-1:0]     i_wr_idx,
  input  logic [7:0]                     i_wr_byte,
  input  logic                           i_req,
  input  usb_spec_pkg::usb_pid_e         i_pid,
  input  logic [$clog2(MAX_PKT)-1:0]     i_rd_idx,
  input  logic                           i_ser_busy,
  input  logic                           i_bit_stb,
  output logic                           o_ack,
  output logic                           o_start,
  output usb_spec_pkg::usb_pid_e         o_pid,
  output logic [$clog2(MAX_PKT+1)-1:0]   o_len,
  output logic [7:0]                     o_rd_byte
);
  import usb_tx_pkg::*;

  localparam int LEN_W = $clog2(MAX_PKT + 1);

  logic [7:0]       mem [MAX_PKT];
  logic [LEN_W-1:0] wr_cnt;
  intake_state_e    state;

  // Payload buffer, written by the producer before it requests.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_wr_en) begin
      mem[i_wr_idx] <= i_wr_byte;
    end
  end

  // Read port for the serializer, no register in the path.
  assign o_rd_byte = mem[i_rd_idx];

  // Launch only on a bit strobe and only when the serializer is free.
  // A held request waits here while a packet is still going out.
  assign o_start = (state == IN_IDLE) && i_req && i_bit_stb && !i_ser_busy;

  // Ack is high for the whole ACKED state, one clock after launch.
  assign o_ack = (state == IN_ACKED);

  // Write count gives the length, stuck at MAX_PKT when full.
  // A launch restarts it for the next packet.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_cnt <= '0;
    end else if (o_start) begin
      wr_cnt <= '0;
    end else if (i_wr_en && (wr_cnt != LEN_W'(MAX_PKT))) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // Four-phase handshake sequencing.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IN_IDLE;
    end else begin
      case (state)
        IN_IDLE:      if (o_start) state <= IN_ACKED;
        IN_ACKED:     if (!i_req) state <= IN_WAIT_DROP;
        IN_WAIT_DROP: state <= IN_IDLE;
        default:      state <= IN_IDLE;
      endcase
    end
  end

  // PID and length stay put for the whole packet.
  always_ff @(posedge i_clk_48MHz) begin
    if (o_start) begin
      o_pid <= i_pid;
      o_len <= wr_cnt;
    end
  end

endmodule

// ==== hw/usb_tx_pkg.sv ====
package usb_tx_pkg;

  // Request handshake states of the intake.
  // ACKED holds o_ack high until the producer drops its request.
  // WAIT_DROP gives one idle clock before a new request is seen.
  typedef enum logic [1:0] {
    IN_IDLE,
    IN_ACKED,
    IN_WAIT_DROP
  } intake_state_e;

  // Packet field being serialized.
  // CRC bytes are skipped for handshake packets.
  typedef enum logic [2:0] {
    SER_IDLE,
    SER_SYNC,
    SER_PID,
    SER_DATA,
    SER_CRC_LO,
    SER_CRC_HI,
    SER_EOP
  } ser_state_e;

endpackage

// ==== hw/usb_tx_top.sv ====
`timescale 1ns/10ps

module usb_tx_top #(
  parameter int MAX_PKT = 8
) (
  input  logic                         i_clk_48MHz,
  input  logic                         i_rst_n,
  input  logic                         i_wr_en,
  input  logic [$clog2(MAX_PKT)-1:0]   i_wr_idx,
  input  logic [7:0]                   i_wr_byte,
  input  logic                         i_req,
  input  usb_spec_pkg::usb_pid_e       i_pid,
  output logic                         o_ack,
  output logic                         o_dp,
  output logic                         o_dn,
  output logic                         o_oe
);
  import usb_spec_pkg::*;

  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int LEN_W = $clog2(MAX_PKT + 1);

  // Intake and serializer link.
  logic             start;
  usb_pid_e         pid;
  logic [LEN_W-1:0] len;
  logic [IDX_W-1:0] rd_idx;
  logic [7:0]       rd_byte;
  logic             busy;

  // Serializer and line driver link.
  logic             bit_stb;
  logic             tx_bit;
  logic             tx_eop;
  logic             tx_active;

  usb_tx_intake #(
    .MAX_PKT(MAX_PKT)
  ) u_intake (
    .i_clk_48MHz(i_clk_48MHz),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (i_wr_en),
    .i_wr_idx   (i_wr_idx),
    .i_wr_byte  (i_wr_byte),
    .i_req      (i_req),
    .i_pid      (i_pid),
    .i_rd_idx   (rd_idx),
    .i_ser_busy (busy),
    .i_bit_stb  (bit_stb),
    .o_ack      (o_ack),
    .o_start    (start),
    .o_pid      (pid),
    .o_len      (len),
    .o_rd_byte  (rd_byte)
  );

  usb_pkt_serializer #(
    .MAX_PKT(MAX_PKT)
  ) u_serializer (
    .i_clk_48MHz(i_clk_48MHz),
    .i_rst_n    (i_rst_n),
    .i_start    (start),
    .i_pid      (pid),
    .i_len      (len),
    .i_rd_byte  (rd_byte),
    .o_rd_idx   (rd_idx),
    .o_busy     (busy),
    .o_bit_stb  (bit_stb),
    .o_tx_bit   (tx_bit),
    .o_tx_eop   (tx_eop),
    .o_tx_active(tx_active)
  );

  usb_line_driver u_line_driver (
    .i_clk_48MHz(i_clk_48MHz),
    .i_rst_n    (i_rst_n),
    .i_bit_stb  (bit_stb),
    .i_tx_bit   (tx_bit),
    .i_tx_eop   (tx_eop),
    .i_tx_active(tx_active),
    .o_dp       (o_dp),
    .o_dn       (o_dn),
    .o_oe       (o_oe)
  );

endmodule

// ==== project.f ====
hw/usb_spec_pkg.sv
hw/usb_tx_pkg.sv
hw/usb_tx_intake.sv
hw/usb_pkt_serializer.sv
hw/usb_line_driver.sv
hw/usb_tx_top.sv
tb/usb_tx_sva.sv
tb/tb_usb_tx.sv

// ==== tb/tb_usb_tx.sv ====
`timescale 1ns/10ps

module tb_usb_tx;
  import usb_spec_pkg::*;

  localparam int MAX_PKT = 8;
  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int NUM_ROWS = 10;
  localparam int NUM_SLOTS = 16;
  localparam int MAX_BYTES = MAX_PKT + 4;

  logic             i_clk_48MHz;
  logic             i_rst_n;
  logic             i_wr_en;
  logic [IDX_W-1:0] i_wr_idx;
  logic [7:0]       i_wr_byte;
  logic             i_req;
  usb_pid_e         i_pid;
  logic             o_ack;
  logic             o_dp;
  logic             o_dn;
  logic             o_oe;

  // Stimulus table, one packet per row.
  string    row_name [NUM_ROWS];
  usb_pid_e row_pid  [NUM_ROWS];
  int       row_len  [NUM_ROWS];
  bit       row_ff   [NUM_ROWS];

  // Decoded packets, one slot per o_oe pulse.
  logic [7:0] dec_byte [NUM_SLOTS][MAX_BYTES];
  int         dec_nbits [NUM_SLOTS];
  int         dec_se0 [NUM_SLOTS];
  int         dec_eop_j [NUM_SLOTS];
  int         dec_stuffed [NUM_SLOTS];
  int         dec_bad_stuff [NUM_SLOTS];
  int         pkt_seen;

  logic [7:0] payload [MAX_PKT];
  integer     seed;
  int         errors;
  int         test_errors;
  int         tests_run;
  int         tests_failed;

  always #5 i_clk_48MHz = ~i_clk_48MHz;

  usb_tx_top #(
    .MAX_PKT(MAX_PKT)
  ) u_usb_tx_top (
    .i_clk_48MHz(i_clk_48MHz),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (i_wr_en),
    .i_wr_idx   (i_wr_idx),
    .i_wr_byte  (i_wr_byte),
    .i_req      (i_req),
    .i_pid      (i_pid),
    .o_ack      (o_ack),
    .o_dp       (o_dp),
    .o_dn       (o_dn),
    .o_oe       (o_oe)
  );

  // Reflected CRC16, LSB first, poly x^16+x^15+x^2+1.
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ b[i]) begin
        c = (c >> 1) ^ 16'ha001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  task automatic set_row(input int r, input string name, input usb_pid_e pid,
                         input int len, input bit fill_ff);
    row_name[r] = name;
    row_pid[r] = pid;
    row_len[r] = len;
    row_ff[r] = fill_ff;
  endtask

  task automatic check_val(input string name, input string what, input int exp_v,
                           input int act_v);
    assert (exp_v == act_v) else begin
      $display("Fail %s %s: expected %0h, actual %0h", name, what, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d check(s) wrong", name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  // Fill the buffer, one write per clock.
  task automatic load_payload(input int len, input bit fill_ff);
    for (int i = 0; i < len; i++) begin
      @(negedge i_clk_48MHz);
      payload[i] = fill_ff ? 8'hff : 8'($random(seed));
      i_wr_en = 1'b1;
      i_wr_idx = IDX_W'(i);
      i_wr_byte = payload[i];
    end
    @(negedge i_clk_48MHz);
    i_wr_en = 1'b0;
  endtask

  // Full four-phase handshake.
  task automatic request(input usb_pid_e pid);
    @(negedge i_clk_48MHz);
    i_req = 1'b1;
    i_pid = pid;
    while (!o_ack) @(negedge i_clk_48MHz);
    i_req = 1'b0;
    while (o_ack) @(negedge i_clk_48MHz);
  endtask

  task automatic wait_packets(input int count);
    while (pkt_seen < count) @(negedge i_clk_48MHz);
  endtask

  // Expected bytes built from the protocol rules.
  task automatic check_packet(input string name, input int slot, input logic [3:0] pid_v,
                              input int len, input bit fill_ff);
    logic [7:0]  exp_b [MAX_BYTES];
    logic [15:0] crc;
    int          n;
    int          nbytes;
    bit          is_data;
    is_data = (pid_v == PID_DATA0) || (pid_v == PID_DATA1);
    exp_b[0] = SYNC_BYTE;
    exp_b[1] = {~pid_v, pid_v};
    n = 2;
    if (is_data) begin
      crc = CRC16_SEED;
      for (int i = 0; i < len; i++) begin
        exp_b[n] = payload[i];
        crc = crc16_byte(crc, payload[i]);
        n++;
      end
      exp_b[n] = ~crc[7:0];
      exp_b[n+1] = ~crc[15:8];
      n += 2;
    end
    nbytes = dec_nbits[slot] / 8;
    check_val(name, "byte count", n, nbytes);
    check_val(name, "bit count mod 8", 0, dec_nbits[slot] % 8);
    for (int i = 0; i < n && i < nbytes; i++) begin
      check_val(name, $sformatf("byte %0d", i), int'(exp_b[i]), int'(dec_byte[slot][i]));
    end
    check_val(name, "SE0 cells", 2, dec_se0[slot]);
    check_val(name, "J cells after SE0", 1, dec_eop_j[slot]);
    check_val(name, "bad stuffed cells", 0, dec_bad_stuff[slot]);
    // Receiver view, CRC over payload and sent CRC.
    if (is_data && nbytes >= 4) begin
      crc = CRC16_SEED;
      for (int i = 2; i < nbytes; i++) begin
        crc = crc16_byte(crc, dec_byte[slot][i]);
      end
      check_val(name, "CRC residue", int'(CRC16_RESIDUE), int'(crc));
    end
    if (fill_ff) begin
      assert (dec_stuffed[slot] > 0) else begin
        $display("Test %s saw no stuffed zero on the line", name);
        test_errors++;
      end
    end
  endtask

  // Second request held high while a data packet is on the line.
  task automatic run_overlap();
    int base;
    int early_acks;
    base = pkt_seen;
    early_acks = 0;
    load_payload(MAX_PKT, 1'b0);
    request(PID_DATA0);
    while (!o_oe) @(negedge i_clk_48MHz);
    i_req = 1'b1;
    i_pid = PID_NAK;
    while (o_oe) begin
      if (o_ack) begin
        early_acks++;
      end
      @(negedge i_clk_48MHz);
    end
    check_val("overlap", "ack clocks while busy", 0, early_acks);
    while (!o_ack) @(negedge i_clk_48MHz);
    i_req = 1'b0;
    while (o_ack) @(negedge i_clk_48MHz);
    wait_packets(base + 2);
    check_packet("overlap", base, PID_DATA0, MAX_PKT, 1'b0);
    check_packet("overlap", base + 1, PID_NAK, 0, 1'b0);
    finish_test("overlap");
  endtask

  // NRZI line decoder, one sample per bit cell from o_oe rising.
  initial begin : line_decoder
    line_state_e cur;
    line_state_e prev;
    logic        bitv;
    int          run;
    int          slot;
    pkt_seen = 0;
    forever begin
      @(negedge i_clk_48MHz);
      if (o_oe) begin
        slot = pkt_seen % NUM_SLOTS;
        prev = LINE_J;
        run = 0;
        dec_nbits[slot] = 0;
        dec_se0[slot] = 0;
        dec_eop_j[slot] = 0;
        dec_stuffed[slot] = 0;
        dec_bad_stuff[slot] = 0;
        while (o_oe) begin
          cur = line_state_e'({o_dp, o_dn});
          if (cur == LINE_SE0) begin
            dec_se0[slot]++;
          end else if (dec_se0[slot] > 0) begin
            dec_eop_j[slot] += (cur == LINE_J) ? 1 : 0;
          end else if (run == STUFF_RUN) begin
            // Stuffed zero, so the line must toggle.
            if (cur == prev) begin
              dec_bad_stuff[slot]++;
            end
            dec_stuffed[slot]++;
            run = 0;
          end else begin
            bitv = (cur == prev);
            if (dec_nbits[slot] / 8 < MAX_BYTES) begin
              dec_byte[slot][dec_nbits[slot] / 8][dec_nbits[slot] % 8] = bitv;
            end
            dec_nbits[slot]++;
            run = bitv ? run + 1 : 0;
          end
          if (cur != LINE_SE0) begin
            prev = cur;
          end
          repeat (4) @(negedge i_clk_48MHz);
        end
        pkt_seen++;
      end
    end
  end

  // Budget from the table, two bit-times per packet bit.
  initial begin : watchdog
    int budget;
    @(posedge i_rst_n);
    budget = 2000;
    for (int r = 0; r < NUM_ROWS; r++) begin
      budget += (row_len[r] + 6) * 8 * 4 * 2;
    end
    budget += (MAX_PKT + 6) * 8 * 4 * 2 + 6 * 8 * 4 * 2;
    repeat (budget) @(posedge i_clk_48MHz);
    $display("Timeout: run did not finish within %0d clocks", budget);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    int base;
    seed = 32'h3ef8_296c;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    i_clk_48MHz = 1'b0;
    i_rst_n = 1'b0;
    i_wr_en = 1'b0;
    i_wr_idx = '0;
    i_wr_byte = '0;
    i_req = 1'b0;
    i_pid = PID_ACK;
    set_row(0, "ack", PID_ACK, 0, 1'b0);
    set_row(1, "nak", PID_NAK, 0, 1'b0);
    set_row(2, "stall", PID_STALL, 0, 1'b0);
    set_row(3, "data0_len1", PID_DATA0, 1, 1'b0);
    set_row(4, "data1_len2", PID_DATA1, 2, 1'b0);
    set_row(5, "data0_len5", PID_DATA0, 5, 1'b0);
    set_row(6, "data1_len8", PID_DATA1, 8, 1'b0);
    set_row(7, "data0_len0", PID_DATA0, 0, 1'b0);
    set_row(8, "data1_ff8", PID_DATA1, 8, 1'b1);
    set_row(9, "data0_ff3", PID_DATA0, 3, 1'b1);
    repeat (3) @(negedge i_clk_48MHz);
    i_rst_n = 1'b1;
    // Quiet bus before any request.
    repeat (8) begin
      @(negedge i_clk_48MHz);
      check_val("reset", "o_ack", 0, int'(o_ack));
      check_val("reset", "o_oe", 0, int'(o_oe));
      check_val("reset", "line", int'(LINE_J), int'({o_dp, o_dn}));
    end
    finish_test("reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      base = pkt_seen;
      load_payload(row_len[r], row_ff[r]);
      request(row_pid[r]);
      wait_packets(base + 1);
      check_packet(row_name[r], base, row_pid[r], row_len[r], row_ff[r]);
      finish_test(row_name[r]);
    end
    run_overlap();
    $display("Tests %0d, failed %0d, wrong checks %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/usb_tx_sva.sv ====
`timescale 1ns/10ps

module usb_tx_sva (
  input logic i_clk_48MHz,
  input logic i_rst_n,
  input logic i_req,
  input logic i_ack,
  input logic i_dp,
  input logic i_dn,
  input logic i_oe,
  input logic i_bit_stb
);
  import usb_spec_pkg::*;

  logic [1:0] line;
  logic [1:0] prev_line;
  logic       se0;
  logic       stb_q;
  int         same_run;
  int         se0_clks;

  assign line = {i_dp, i_dn};
  assign se0 = (line == LINE_SE0);

  // Line updates on the strobe edge, so compare one clock later.
  always_ff @(posedge i_clk_48MHz or negedge i_rst_n) begin
    if (!i_rst_n) begin
      stb_q <= 1'b0;
      prev_line <= LINE_J;
      same_run <= 0;
      se0_clks <= 0;
    end else begin
      stb_q <= i_bit_stb;
      se0_clks <= se0 ? se0_clks + 1 : 0;
      if (i_bit_stb) begin
        prev_line <= line;
      end
      // A repeated state is a one in NRZI.
      if (stb_q) begin
        if (!i_oe || se0 || (line != prev_line)) begin
          same_run <= 0;
        end else begin
          same_run <= same_run + 1;
        end
      end
    end
  end

  // Idle bus is J.
  a_idle_j: assert property (@(posedge i_clk_48MHz) disable iff (!i_rst_n)
    !i_oe |-> (line == LINE_J))
    else $error("line not at J while output enable is low");

  // Stuffing caps the run of ones.
  a_stuff_run: assert property (@(posedge i_clk_48MHz) disable iff (!i_rst_n)
    same_run <= STUFF_RUN)
    else $error("more than %0d identical cells on the line", STUFF_RUN);

  // Four-phase order, request drops before ack.
  a_ack_drop: assert property (@(posedge i_clk_48MHz) disable iff (!i_rst_n)
    $fell(i_ack) |-> !$past(i_req))
    else $error("ack dropped while request still high");

  // EOP holds SE0 for two cells of four clocks.
  a_se0_len: assert property (@(posedge i_clk_48MHz) disable iff (!i_rst_n)
    $fell(se0) |-> (se0_clks == 8))
    else $error("SE0 did not last exactly two bit cells");

endmodule

bind usb_tx_top usb_tx_sva u_sva (
  .i_clk_48MHz(i_clk_48MHz),
  .i_rst_n    (i_rst_n),
  .i_req      (i_req),
  .i_ack      (o_ack),
  .i_dp       (o_dp),
  .i_dn       (o_dn),
  .i_oe       (o_oe),
  .i_bit_stb  (bit_stb)
);
